// File: src/memSys_consts.svh
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// bus widths seen by the core
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define TAG_WIDTH 4

// unified RAM is 2^RAM_ADDR_BITS bytes, upper address bits are ignored
`define RAM_ADDR_BITS 12

// slots per port queue, which is also the initial client credit count
`define PORT_QUEUE_DEPTH 4

// access length codes
`define LEN_BYTE 2'd0
`define LEN_HALF 2'd1
`define LEN_WORD 2'd2

`endif

// File: src/memPkg.sv
`include "memSys_consts.svh"

package memPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [`DATA_WIDTH-1:0] dataT;
    typedef logic [`TAG_WIDTH-1:0]  tagT;
    typedef logic [1:0]             lenT;

    localparam int  portQueueDepth = `PORT_QUEUE_DEPTH;
    localparam lenT lenWord        = `LEN_WORD;

    // load or store from the store/load buffer
    typedef struct packed {
        logic isStore;
        addrT addr;
        dataT data;
        lenT  len;
        tagT  tag;
    } dataReqT;

    typedef struct packed {
        dataT data;
        tagT  tag;
    } dataRespT;

    // what the controller sees, the tag stays in the port
    typedef struct packed {
        logic isStore;
        addrT addr;
        dataT data;
        lenT  len;
    } memReqT;

    typedef enum logic {PORT_DATA, PORT_FETCH} portSelT;

    typedef enum logic [1:0] {IDLE, XFER, DONE} ctrlStateT;

endpackage

// File: src/dataPort.sv
`timescale 1ns/10ps

module dataPort
    import memPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     reqValid,
    input  dataReqT  req,
    output logic     credit,
    output logic     respValid,
    output dataRespT resp,
    output logic     headValid,
    output memReqT   memReq,
    input  logic     grant,
    input  logic     memDone,
    input  dataT     memData
);
    localparam int ptrBits = $clog2(portQueueDepth);

    dataReqT            queue [portQueueDepth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits:0]   count;
    dataReqT            head;
    tagT                inFlightTag;

    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        if (ptr == ptrBits'(portQueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head      = queue[rdPtr];
    assign headValid = (count != '0);
    assign memReq    = '{isStore: head.isStore, addr: head.addr,
                         data: head.data, len: head.len};

    // a slot frees the moment its entry wins arbitration
    assign credit = grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (reqValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (grant) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({reqValid, grant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            queue[wrPtr] <= req;
        end
        // only one request is in flight, so one tag register is enough
        if (grant) begin
            inFlightTag <= head.tag;
        end
        if (memDone) begin
            resp <= '{data: memData, tag: inFlightTag};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
        end else begin
            respValid <= memDone;
        end
    end

endmodule

// File: src/fetchPort.sv
`timescale 1ns/10ps

module fetchPort
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   reqValid,
    input  addrT   reqAddr,
    output logic   credit,
    output logic   respValid,
    output dataT   respInstr,
    output logic   headValid,
    output memReqT memReq,
    input  logic   grant,
    input  logic   memDone,
    input  dataT   memData
);
    localparam int ptrBits = $clog2(portQueueDepth);

    addrT               queue [portQueueDepth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits:0]   count;

    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        if (ptr == ptrBits'(portQueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // fetches are always full-word reads
    assign headValid = (count != '0);
    assign memReq    = '{isStore: 1'b0, addr: queue[rdPtr], data: '0, len: lenWord};
    assign credit    = grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (reqValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (grant) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({reqValid, grant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            queue[wrPtr] <= reqAddr;
        end
        if (memDone) begin
            respInstr <= memData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
        end else begin
            respValid <= memDone;
        end
    end

endmodule

// File: src/memArbiter.sv
`timescale 1ns/10ps

module memArbiter
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   dataHeadValid,
    input  memReqT dataReq,
    output logic   dataGrant,
    input  logic   fetchHeadValid,
    input  memReqT fetchReq,
    output logic   fetchGrant,
    input  logic   ctrlReady,
    output logic   start,
    output memReqT ctrlReq,
    input  logic   ctrlDone,
    output logic   dataDone,
    output logic   fetchDone
);
    // owner of the current access, and also the last port served
    portSelT owner;

    always_comb begin
        dataGrant  = 1'b0;
        fetchGrant = 1'b0;
        if (ctrlReady) begin
            if (dataHeadValid && fetchHeadValid) begin
                // both waiting so the port not served last goes first
                dataGrant  = (owner == PORT_FETCH);
                fetchGrant = (owner == PORT_DATA);
            end else begin
                dataGrant  = dataHeadValid;
                fetchGrant = fetchHeadValid;
            end
        end
    end

    assign start   = dataGrant | fetchGrant;
    assign ctrlReq = fetchGrant ? fetchReq : dataReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= PORT_FETCH;
        end else if (dataGrant) begin
            owner <= PORT_DATA;
        end else if (fetchGrant) begin
            owner <= PORT_FETCH;
        end
    end

    // owner cannot change before done since grants wait for ready
    assign dataDone  = ctrlDone && (owner == PORT_DATA);
    assign fetchDone = ctrlDone && (owner == PORT_FETCH);

endmodule

// File: src/memCtrl.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module memCtrl
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  memReqT req,
    output logic   ready,
    output logic   done,
    output dataT   rdata
);
    localparam int ramBytes = 1 << `RAM_ADDR_BITS;

    ctrlStateT                 state;
    memReqT                    curReq;
    logic [1:0]                byteCnt;
    logic [1:0]                lastByte;
    logic [`RAM_ADDR_BITS-1:0] byteAddr;
    logic [7:0]                ram [ramBytes];
    dataT                      rdataReg;

    always_comb begin
        case (curReq.len)
            `LEN_BYTE: lastByte = 2'd0;
            `LEN_HALF: lastByte = 2'd1;
            default:   lastByte = 2'd3;
        endcase
    end

    // truncation to the RAM width makes the address wrap inside the array
    assign byteAddr = curReq.addr[`RAM_ADDR_BITS-1:0] + `RAM_ADDR_BITS'(byteCnt);

    assign ready = (state == IDLE);
    assign done  = (state == DONE);
    assign rdata = rdataReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            byteCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= XFER;
                        byteCnt <= '0;
                    end
                end
                XFER: begin
                    if (byteCnt == lastByte) begin
                        state <= DONE;
                    end else begin
                        byteCnt <= byteCnt + 2'd1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            curReq   <= req;
            // upper bytes of a short load and all of a store read back as zero
            rdataReg <= '0;
        end else if (state == XFER && !curReq.isStore) begin
            rdataReg[{byteCnt, 3'b000} +: 8] <= ram[byteAddr];
        end
    end

    // little-endian, byte 0 of the word goes to the lowest address
    always_ff @(posedge clk) begin
        if (state == XFER && curReq.isStore) begin
            ram[byteAddr] <= curReq.data[{byteCnt, 3'b000} +: 8];
        end
    end

endmodule

// File: src/memSubsystem.sv
`timescale 1ns/10ps

module memSubsystem (
    input  logic             clk,
    input  logic             rst,
    input  logic             dataReqValid,
    input  memPkg::dataReqT  dataReq,
    output logic             dataCredit,
    output logic             dataRespValid,
    output memPkg::dataRespT dataResp,
    input  logic             fetchReqValid,
    input  memPkg::addrT     fetchAddr,
    output logic             fetchCredit,
    output logic             fetchRespValid,
    output memPkg::dataT     fetchInstr
);
    logic           dataHeadValid;
    logic           dataGrant;
    logic           dataDone;
    memPkg::memReqT dataMemReq;
    logic           fetchHeadValid;
    logic           fetchGrant;
    logic           fetchDone;
    memPkg::memReqT fetchMemReq;
    logic           ctrlReady;
    logic           ctrlStart;
    logic           ctrlDone;
    memPkg::memReqT ctrlReq;
    memPkg::dataT   ctrlData;

    dataPort dataPortInst (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (dataReqValid),
        .req       (dataReq),
        .credit    (dataCredit),
        .respValid (dataRespValid),
        .resp      (dataResp),
        .headValid (dataHeadValid),
        .memReq    (dataMemReq),
        .grant     (dataGrant),
        .memDone   (dataDone),
        .memData   (ctrlData)
    );

    fetchPort fetchPortInst (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (fetchReqValid),
        .reqAddr   (fetchAddr),
        .credit    (fetchCredit),
        .respValid (fetchRespValid),
        .respInstr (fetchInstr),
        .headValid (fetchHeadValid),
        .memReq    (fetchMemReq),
        .grant     (fetchGrant),
        .memDone   (fetchDone),
        .memData   (ctrlData)
    );

    memArbiter arbiterInst (
        .clk            (clk),
        .rst            (rst),
        .dataHeadValid  (dataHeadValid),
        .dataReq        (dataMemReq),
        .dataGrant      (dataGrant),
        .fetchHeadValid (fetchHeadValid),
        .fetchReq       (fetchMemReq),
        .fetchGrant     (fetchGrant),
        .ctrlReady      (ctrlReady),
        .start          (ctrlStart),
        .ctrlReq        (ctrlReq),
        .ctrlDone       (ctrlDone),
        .dataDone       (dataDone),
        .fetchDone      (fetchDone)
    );

    memCtrl ctrlInst (
        .clk   (clk),
        .rst   (rst),
        .start (ctrlStart),
        .req   (ctrlReq),
        .ready (ctrlReady),
        .done  (ctrlDone),
        .rdata (ctrlData)
    );

endmodule

// File: sim/memSubsystemTb.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module memSubsystemTb
    import memPkg::*;
();
    localparam int fillWords     = 128;
    localparam int dataOps       = 200;
    localparam int fetchOps      = 150;
    // 8 cycles per request for each port over every request of the run
    localparam int timeoutCycles = 8 * 2 * (fillWords + dataOps + fetchOps);
    // with round-robin a waiting port is answered within one access of each port
    localparam int maxRespGap    = 2 * 8;

    logic     clk = 1'b0;
    logic     rst;
    logic     dataReqValid;
    dataReqT  dataReq;
    logic     dataCredit;
    logic     dataRespValid;
    dataRespT dataResp;
    logic     fetchReqValid;
    addrT     fetchAddr;
    logic     fetchCredit;
    logic     fetchRespValid;
    dataT     fetchInstr;

    logic [7:0]  refMem [1 << `RAM_ADDR_BITS];
    logic [31:0] lfsr = 32'hf4b6_1651;
    dataRespT    dataExp [$];
    dataT        fetchExp [$];
    int          dataSent = 0;
    int          dataBack = 0;
    int          fetchSent = 0;
    int          fetchBack = 0;
    int          dataWait = 0;
    int          fetchWait = 0;

    memSubsystem DUT (.*);

    always #2 clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic int byteCount(input lenT len);
        if (len == `LEN_BYTE) begin
            return 1;
        end
        return (len == `LEN_HALF) ? 2 : 4;
    endfunction

    function automatic logic [`RAM_ADDR_BITS-1:0] ramIndex(input addrT addr, input int i);
        return addr[`RAM_ADDR_BITS-1:0] + `RAM_ADDR_BITS'(i);
    endfunction

    // expected load value is little-endian and zero-extended
    function automatic dataT refLoad(input addrT addr, input lenT len);
        dataT val;
        val = '0;
        for (int i = 0; i < byteCount(len); i++) begin
            val[8*i +: 8] = refMem[ramIndex(addr, i)];
        end
        return val;
    endfunction

    function automatic void refStore(input addrT addr, input dataT data, input lenT len);
        for (int i = 0; i < byteCount(len); i++) begin
            refMem[ramIndex(addr, i)] = data[8*i +: 8];
        end
    endfunction

    function automatic int dataCredits();
        return portQueueDepth - dataSent + dataBack;
    endfunction

    function automatic int fetchCredits();
        return portQueueDepth - fetchSent + fetchBack;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkDataResp(input dataRespT expected, input dataRespT actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] dataResp expected data %h tag %h, got data %h tag %h",
                              expected.data, expected.tag, actual.data, actual.tag));
        end
    endtask

    task automatic checkInstr(input dataT expected, input dataT actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] fetchInstr expected %h, got %h", expected, actual));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        dataReqValid  <= 1'b0;
        fetchReqValid <= 1'b0;
    endtask

    // a store is applied to the reference when sent, and answers with zero data
    task automatic sendData(input dataReqT r);
        dataRespT exp;
        exp.tag  = r.tag;
        exp.data = r.isStore ? '0 : refLoad(r.addr, r.len);
        if (r.isStore) begin
            refStore(r.addr, r.data, r.len);
        end
        dataExp.push_back(exp);
        dataReqValid <= 1'b1;
        dataReq      <= r;
        dataSent++;
    endtask

    task automatic sendFetch(input addrT addr);
        fetchExp.push_back(refLoad(addr, `LEN_WORD));
        fetchReqValid <= 1'b1;
        fetchAddr     <= addr;
        fetchSent++;
    endtask

    function automatic dataReqT randomDataReq();
        dataReqT     r;
        logic [31:0] bits;
        bits   = randBits(2);
        r.len  = (bits[1:0] == 2'd3) ? `LEN_WORD : bits[1:0];
        bits   = randBits(12);
        // bits 15:12 lie above the RAM and must not matter
        r.addr = {16'h0, bits[11:8], 4'h0, bits[7:0]};
        if (r.len == `LEN_WORD) begin
            r.addr[1:0] = 2'b00;
        end else if (r.len == `LEN_HALF) begin
            r.addr[0] = 1'b0;
        end
        bits      = randBits(1);
        r.isStore = bits[0];
        r.data    = r.isStore ? randBits(32) : '0;
        bits      = randBits(4);
        r.tag     = bits[3:0];
        return r;
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            dataBack  += int'(dataCredit);
            fetchBack += int'(fetchCredit);
            if (dataCredits() > portQueueDepth || fetchCredits() > portQueueDepth) begin
                failRun("a credit came back with no request outstanding");
            end
            dataWait  = (dataExp.size() != 0 && !dataRespValid) ? dataWait + 1 : 0;
            fetchWait = (fetchExp.size() != 0 && !fetchRespValid) ? fetchWait + 1 : 0;
            if (dataWait > maxRespGap || fetchWait > maxRespGap) begin
                failRun("a port with requests outstanding went too long without a response");
            end
            if (dataRespValid && dataExp.size() == 0) begin
                failRun("a data response arrived with no request outstanding");
            end else if (dataRespValid) begin
                checkDataResp(dataExp.pop_front(), dataResp);
            end
            if (fetchRespValid && fetchExp.size() == 0) begin
                failRun("a fetch response arrived with no request outstanding");
            end else if (fetchRespValid) begin
                checkInstr(fetchExp.pop_front(), fetchInstr);
            end
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        failRun("timeout: responses still missing");
    end

    initial begin
        dataReqT     r;
        logic [31:0] bits;
        int          dataDone;
        int          fetchDone;
        rst           = 1'b1;
        dataReqValid  = 1'b0;
        dataReq       = '0;
        fetchReqValid = 1'b0;
        fetchAddr     = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // the monitor flags any credit or response in this quiet stretch
        repeat (12) nextCycle();

        // words into the data region at 0x000 and the fetch region at 0x800
        for (int i = 0; i < fillWords; i++) begin
            nextCycle();
            while (dataCredits() == 0) begin
                nextCycle();
            end
            bits      = randBits(32);
            r.isStore = 1'b1;
            r.addr    = (i < 64) ? addrT'(4 * i) : addrT'(32'h800 + 4 * (i - 64));
            r.data    = bits;
            r.len     = `LEN_WORD;
            r.tag     = tagT'(i);
            sendData(r);
        end
        nextCycle();
        while (dataExp.size() != 0) begin
            nextCycle();
        end

        // both clients are busy at once and data stays below 0x800
        dataDone  = 0;
        fetchDone = 0;
        while (dataDone < dataOps || fetchDone < fetchOps) begin
            nextCycle();
            if (dataDone < dataOps && dataCredits() > 0) begin
                bits = randBits(2);
                if (bits[1:0] != 2'b00) begin
                    sendData(randomDataReq());
                    dataDone++;
                end
            end
            if (fetchDone < fetchOps && fetchCredits() > 0) begin
                bits = randBits(2);
                if (bits[1:0] != 2'b00) begin
                    bits = randBits(6);
                    sendFetch(addrT'(32'h800 + 4 * int'(bits[5:0])));
                    fetchDone++;
                end
            end
        end
        nextCycle();
        while (dataExp.size() != 0 || fetchExp.size() != 0) begin
            nextCycle();
        end
        repeat (4) nextCycle();

        if (dataCredits() == portQueueDepth && fetchCredits() == portQueueDepth) begin
            $display("Testbench passed");
            $finish;
        end else begin
            failRun("not every credit came back to the clients");
        end
    end

endmodule

// File: all.f
+incdir+src
src/memPkg.sv
src/dataPort.sv
src/fetchPort.sv
src/memArbiter.sv
src/memCtrl.sv
src/memSubsystem.sv
sim/memSubsystemTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run the memory subsystem testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module memSubsystemTb \
    -f all.f -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "run.sh: Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "run.sh: simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Testbench passed" sim.log; then
    echo "run.sh: PASS"
    exit 0
fi
echo "run.sh: FAIL"
exit 1
